// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_system_tb
FILELIST = mem_system.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/mem_system_checker.sv ====
////////////////////////////////////////
// Memory system checker
// Watches the DUT ports and scores each
// request against its expected values
////////////////////////////////////////
`timescale 1ns/10ps

module mem_system_checker #(
   parameter int done_limit = 20
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        rd,
   input  logic        wr,
   input  logic [15:0] data_out,
   input  logic        done,
   input  logic        stall,
   input  logic        cache_hit,
   input  logic        exp_read,
   input  logic [15:0] exp_data,
   input  logic        exp_hit,
   input  int          test_id,
   output int          pass_count,
   output int          fail_count,
   output int          error_count
);

   logic pending;
   int   wait_cycles;
   int   test_errors;
   int   cur_test;

   task automatic mismatch(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
      $display("Mismatch test %0d %s: expected 0x%h, got 0x%h",
               cur_test, name, expected, actual);
      test_errors++;
      error_count++;
   endtask

   // Outputs stay zero outside a done cycle
   task automatic check_quiet();
      if (cache_hit !== 1'b0) begin
         mismatch("cache_hit", 16'h0, 16'(cache_hit));
      end
      if (data_out !== 16'h0) begin
         mismatch("data_out", 16'h0, data_out);
      end
   endtask

   task automatic finish_test();
      if (test_errors == 0) begin
         pass_count++;
         $display("Test %0d (%s) passed", cur_test, exp_read ? "read" : "write");
      end else begin
         fail_count++;
         $display("Test %0d (%s) failed", cur_test, exp_read ? "read" : "write");
      end
      test_errors = 0;
      pending     = 1'b0;
   endtask

   ////////////////////////////////////////
   // Per-cycle scoring at the rising edge
   ////////////////////////////////////////

   always @(posedge clk) begin
      if (reset) begin
         pending     = 1'b0;
         wait_cycles = 0;
         test_errors = 0;
         cur_test    = 0;
         pass_count  = 0;
         fail_count  = 0;
         error_count = 0;
      end else if (pending) begin
         // Busy from acceptance through done
         if (stall !== 1'b1) begin
            mismatch("stall", 16'h1, 16'(stall));
         end
         if (done === 1'b1) begin
            if (cache_hit !== exp_hit) begin
               mismatch("cache_hit", 16'(exp_hit), 16'(cache_hit));
            end
            if (exp_read && data_out !== exp_data) begin
               mismatch("data_out", exp_data, data_out);
            end
            if (!exp_read && data_out !== 16'h0) begin
               mismatch("data_out", 16'h0, data_out);
            end
            finish_test();
         end else begin
            check_quiet();
            wait_cycles++;
            if (wait_cycles >= done_limit) begin
               $display("Test %0d: done never arrived within %0d cycles",
                        cur_test, done_limit);
               test_errors++;
               error_count++;
               finish_test();
            end
         end
      end else begin
         // Idle between requests
         if (stall !== 1'b0) begin
            mismatch("stall", 16'h0, 16'(stall));
         end
         if (done !== 1'b0) begin
            $display("Test %0d: done pulsed with no request outstanding", cur_test);
            test_errors++;
            error_count++;
         end
         check_quiet();
         if (rd || wr) begin
            pending     = 1'b1;
            wait_cycles = 0;
            cur_test    = test_id;
         end
      end
   end

endmodule

// ==== dv/mem_system_tb.sv ====
////////////////////////////////////////
// Memory system testbench
// Clock, reset, file-driven requests and
// a run-time watchdog around the DUT
////////////////////////////////////////
`timescale 1ns/10ps

module mem_system_tb;

   localparam string test_file  = "dv/mem_system_tests.txt";
   localparam int    done_limit = 20;

   logic        clk;
   logic        reset;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;

   // Expected values of the request in flight
   logic        exp_read;
   logic [15:0] exp_data;
   logic        exp_hit;
   int          test_id;
   int          pass_count;
   int          fail_count;
   int          error_count;

   // Requests from the data file
   logic        q_write [$];
   logic [15:0] q_addr  [$];
   logic [15:0] q_wdata [$];
   logic [15:0] q_rdata [$];
   logic        q_hit   [$];
   int          num_tests;
   logic        loaded;

   mem_system #(.mem_words(32768), .sets(256)) i_mem_system (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit)
   );

   mem_system_checker #(.done_limit(done_limit)) scoreboard (
      .clk         (clk),
      .reset       (reset),
      .rd          (rd),
      .wr          (wr),
      .data_out    (data_out),
      .done        (done),
      .stall       (stall),
      .cache_hit   (cache_hit),
      .exp_read    (exp_read),
      .exp_data    (exp_data),
      .exp_hit     (exp_hit),
      .test_id     (test_id),
      .pass_count  (pass_count),
      .fail_count  (fail_count),
      .error_count (error_count)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Lines starting with # are column notes
   task automatic load_tests();
      int          fd;
      int          fields;
      string       line;
      logic [7:0]  op;
      logic [15:0] a;
      logic [15:0] d;
      logic [15:0] e;
      logic        h;
      fd = $fopen(test_file, "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
               fields = $sscanf(line, "%s %h %h %h %h", op, a, d, e, h);
               if (fields == 5) begin
                  q_write.push_back(op == "W");
                  q_addr.push_back(a);
                  q_wdata.push_back(d);
                  q_rdata.push_back(e);
                  q_hit.push_back(h);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // One strobe, then the opposite strobe while busy, then wait for done
   task automatic run_request(input int idx);
      int n;
      while (stall !== 1'b0) begin
         @(negedge clk);
      end
      test_id  = idx;
      exp_read = !q_write[idx];
      exp_data = q_rdata[idx];
      exp_hit  = q_hit[idx];
      addr     = q_addr[idx];
      data_in  = q_wdata[idx];
      rd       = !q_write[idx];
      wr       = q_write[idx];
      @(negedge clk);
      // Must be ignored by the DUT
      rd      = q_write[idx];
      wr      = !q_write[idx];
      data_in = 16'hffff;
      n = 0;
      while (done !== 1'b1 && n < done_limit + 2) begin
         @(negedge clk);
         rd = 1'b0;
         wr = 1'b0;
         n++;
      end
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
   endtask

   initial begin
      reset     = 1'b1;
      rd        = 1'b0;
      wr        = 1'b0;
      addr      = '0;
      data_in   = '0;
      exp_read  = 1'b0;
      exp_data  = '0;
      exp_hit   = 1'b0;
      test_id   = 0;
      loaded    = 1'b0;
      load_tests();
      num_tests = q_addr.size();
      loaded    = 1'b1;
      if (num_tests == 0) begin
         $display("No tests could be read from %s", test_file);
         $display("Testbench failed");
      end else begin
         repeat (8) @(posedge clk);
         @(negedge clk);
         reset = 1'b0;
         repeat (2) @(negedge clk);
         for (int i = 0; i < num_tests; i++) begin
            run_request(i);
         end
         repeat (3) @(negedge clk);
         $display("Summary: %0d of %0d tests passed, %0d failed, %0d errors",
                  pass_count, num_tests, fail_count, error_count);
         if (error_count == 0 && pass_count == num_tests) begin
            $display("Testbench passed");
         end else begin
            $display("Testbench failed");
         end
      end
      $finish;
   end

   // Watchdog scaled by the number of tests
   initial begin
      wait (loaded === 1'b1);
      repeat (num_tests * 20 + 100) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles",
               num_tests * 20 + 100);
      $display("Testbench failed");
      $finish;
   end

endmodule

// ==== dv/mem_system_tests.txt ====
# op addr wdata exp_rdata exp_hit, the last four in hex
# op R reads and W writes; exp_rdata is unused on writes
R 0010 0000 0000 0
R 0010 0000 0000 1
W 0022 1234 0000 0
R 0022 0000 1234 1
R 0020 0000 0000 1
R 0024 0000 0000 1
R 0026 0000 0000 1
W 0026 beef 0000 1
R 0026 0000 beef 1
W 0842 a5a5 0000 0
W 1044 5a5a 0000 0
R 0842 0000 a5a5 1
R 1044 0000 5a5a 1
R 1846 0000 0000 0
R 0842 0000 a5a5 0
R 1044 0000 5a5a 0
R 0842 0000 a5a5 1
R 1846 0000 0000 0
R 1044 0000 5a5a 0
R 0820 0000 0000 0
W 1020 0f0f 0000 0
R 0822 0000 0000 0
R 0026 0000 beef 0
R 0022 0000 1234 1
R 1020 0000 0f0f 0
R 0022 0000 1234 0

// ==== mem_system.f ====
src/mem_system_pkg.sv
src/mem_system_if.sv
src/cache_way.sv
src/banked_mem.sv
src/cache_ctrl.sv
src/mem_system.sv
dv/mem_system_checker.sv
dv/mem_system_tb.sv

// ==== src/banked_mem.sv ====
////////////////////////////////////////
// Banked memory
// Four word banks picked by addr[2:1]
// with a pipelined two-cycle read
////////////////////////////////////////
`timescale 1ns/10ps

module banked_mem #(
   parameter int mem_words = 32768
) (
   input logic clk,
   input logic reset,
   mem_if.mem  bus
);

   localparam int word_w = mem_system_pkg::word_w;
   localparam int lat    = mem_system_pkg::mem_rd_latency;
   localparam int banks  = mem_system_pkg::words_per_line;
   localparam int bank_w = $clog2(banks);
   localparam int rows   = mem_words / banks;
   localparam int row_w  = $clog2(rows);

   logic [word_w-1:0] bank_mem [banks][rows];
   // Read pipeline per bank, stage 0 fed from the array
   logic [word_w-1:0] rd_pipe  [lat][banks];
   logic [banks-1:0]  vld_pipe [lat];

   logic [bank_w-1:0] bank_sel;
   logic [row_w-1:0]  row_sel;
   logic [word_w-1:0] rd_mux;

   // Consecutive words land in different banks
   assign bank_sel = bus.addr[bank_w:1];
   assign row_sel  = bus.addr[bank_w+1 +: row_w];

   ////////////////////////////////////////
   // Bank arrays
   ////////////////////////////////////////

   // Banks power up cleared so untouched words read back as zero
   initial begin
      for (int b = 0; b < banks; b++) begin
         for (int r = 0; r < rows; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   // Write lands at the next edge
   always @(posedge clk) begin
      if (bus.wr) begin
         bank_mem[bank_sel][row_sel] <= bus.data_in;
      end
   end

   ////////////////////////////////////////
   // Read pipeline
   ////////////////////////////////////////

   // Data stages
   always_ff @(posedge clk) begin
      for (int b = 0; b < banks; b++) begin
         if (bus.rd && bank_sel == bank_w'(b)) begin
            rd_pipe[0][b] <= bank_mem[b][row_sel];
         end
         for (int s = 1; s < lat; s++) begin
            rd_pipe[s][b] <= rd_pipe[s-1][b];
         end
      end
   end

   // Tracks which bank owns each stage
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < lat; s++) begin
            vld_pipe[s] <= '0;
         end
      end else begin
         vld_pipe[0] <= bus.rd ? (banks'(1) << bank_sel) : '0;
         for (int s = 1; s < lat; s++) begin
            vld_pipe[s] <= vld_pipe[s-1];
         end
      end
   end

   // Zero when no read is completing
   always_comb begin
      rd_mux = '0;
      for (int b = 0; b < banks; b++) begin
         if (vld_pipe[lat-1][b]) begin
            rd_mux = rd_mux | rd_pipe[lat-1][b];
         end
      end
   end

   assign bus.data_out = rd_mux;

   // Controller never reads and writes together
   a_rd_wr_exclusive : assert property (
      @(posedge clk) disable iff (reset)
      !(bus.rd && bus.wr)
   );

endmodule

// ==== src/cache_ctrl.sv ====
////////////////////////////////////////
// Cache controller
// Request capture, way selection and the
// FSM for compare, write-back and fill
////////////////////////////////////////
`timescale 1ns/10ps

module cache_ctrl (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              rd,
   input  logic                              wr,
   input  logic [mem_system_pkg::word_w-1:0] addr,
   input  logic [mem_system_pkg::word_w-1:0] data_in,
   output logic [mem_system_pkg::word_w-1:0] data_out,
   output logic                              done,
   output logic                              stall,
   output logic                              cache_hit,
   way_if.ctrl                               way0,
   way_if.ctrl                               way1,
   mem_if.ctrl                               mem
);

   localparam int word_w   = mem_system_pkg::word_w;
   localparam int tag_w    = mem_system_pkg::tag_w;
   localparam int index_w  = mem_system_pkg::index_w;
   localparam int offset_w = mem_system_pkg::offset_w;
   localparam int cnt_w    = mem_system_pkg::cnt_w;

   mem_system_pkg::ctrl_state_t state;
   mem_system_pkg::ctrl_state_t next_state;

   logic [word_w-1:0]   req_addr;
   logic [word_w-1:0]   req_data;
   logic [cnt_w-1:0]    cnt;
   logic                victim;
   logic                flag0;
   logic                flag1;

   logic [tag_w-1:0]    req_tag;
   logic [index_w-1:0]  req_index;
   logic                hit0;
   logic                hit1;
   logic                real_hit;
   logic                evict;
   logic                fill_way;
   logic                sel_way;
   logic [word_w-1:0]   sel_data;
   logic [tag_w-1:0]    sel_tag;
   logic                is_wr;
   logic                in_cmp;
   logic                in_wb;
   logic                in_fill;
   logic [1:0]          fill_word;
   // Way controls shared by both ways before enable gating
   logic                en0;
   logic                en1;
   logic                c_comp;
   logic                c_write;
   logic [offset_w-1:0] c_offset;
   logic [word_w-1:0]   c_data;

   ////////////////////////////////////////
   // Decode and way selection
   ////////////////////////////////////////

   assign req_tag   = req_addr[word_w-1 -: tag_w];
   assign req_index = req_addr[offset_w +: index_w];

   assign is_wr   = state inside {mem_system_pkg::wr_compare, mem_system_pkg::wr_writeback,
                                  mem_system_pkg::wr_fill, mem_system_pkg::wr_return};
   assign in_cmp  = state inside {mem_system_pkg::rd_compare, mem_system_pkg::wr_compare};
   assign in_wb   = state inside {mem_system_pkg::rd_writeback, mem_system_pkg::wr_writeback};
   assign in_fill = state inside {mem_system_pkg::rd_fill, mem_system_pkg::wr_fill};

   assign hit0     = way0.hit && way0.valid;
   assign hit1     = way1.hit && way1.valid;
   assign real_hit = hit0 || hit1;

   // Victim flips after this compare, so the evicted way is the other one
   assign evict = way0.valid && way1.valid && (victim ? way0.dirty : way1.dirty);

   // Invalid way first, then the victim
   assign fill_way = !flag0 ? 1'b0 : (!flag1 ? 1'b1 : victim);
   assign sel_way  = hit0 ? 1'b0 : (hit1 ? 1'b1 : victim);
   assign sel_data = sel_way ? way1.data_out : way0.data_out;
   assign sel_tag  = sel_way ? way1.tag_out : way0.tag_out;

   // Memory data trails the read strobe by two counts
   assign fill_word = cnt[1:0] - 2'd2;

   // Way ports
   assign way0.tag      = req_tag;
   assign way0.index    = req_index;
   assign way0.offset   = c_offset;
   assign way0.data_in  = c_data;
   assign way0.enable   = en0;
   assign way0.comp     = en0 && c_comp;
   assign way0.write    = en0 && c_write;
   assign way0.valid_in = c_write && !c_comp;
   assign way1.tag      = req_tag;
   assign way1.index    = req_index;
   assign way1.offset   = c_offset;
   assign way1.data_in  = c_data;
   assign way1.enable   = en1;
   assign way1.comp     = en1 && c_comp;
   assign way1.write    = en1 && c_write;
   assign way1.valid_in = c_write && !c_comp;

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= mem_system_pkg::idle;
         victim <= 1'b0;
         flag0  <= 1'b0;
         flag1  <= 1'b0;
      end else begin
         state <= next_state;
         if (in_cmp) begin
            victim <= !victim;
         end
         if (state == mem_system_pkg::idle || in_cmp) begin
            flag0 <= way0.valid;
            flag1 <= way1.valid;
         end
      end
   end

   // Miss counter wraps after the fourth write-back word
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt <= '0;
      end else if (in_fill || (in_wb && cnt != cnt_w'(3))) begin
         cnt <= cnt + 1'b1;
      end else begin
         cnt <= '0;
      end
   end

   // Request held for the whole miss
   always_ff @(posedge clk) begin
      if (state == mem_system_pkg::idle) begin
         req_addr <= addr;
         req_data <= data_in;
      end
   end

   ////////////////////////////////////////
   // FSM outputs and next state
   ////////////////////////////////////////

   always_comb begin
      next_state  = state;
      done        = 1'b0;
      stall       = 1'b1;
      cache_hit   = 1'b0;
      data_out    = '0;
      en0         = 1'b0;
      en1         = 1'b0;
      c_comp      = 1'b0;
      c_write     = 1'b0;
      c_offset    = req_addr[offset_w-1:0];
      c_data      = req_data;
      mem.addr    = '0;
      mem.data_in = '0;
      mem.wr      = 1'b0;
      mem.rd      = 1'b0;

      case (state)
         mem_system_pkg::idle: begin
            stall = 1'b0;
            if (rd) begin
               next_state = mem_system_pkg::rd_compare;
            end else if (wr) begin
               next_state = mem_system_pkg::wr_compare;
            end
         end
         mem_system_pkg::rd_compare, mem_system_pkg::wr_compare: begin
            // Probe both ways at once
            en0       = 1'b1;
            en1       = 1'b1;
            c_comp    = 1'b1;
            c_write   = is_wr;
            done      = real_hit;
            cache_hit = real_hit;
            if (real_hit && !is_wr) begin
               data_out = sel_data;
            end
            if (real_hit) begin
               next_state = mem_system_pkg::idle;
            end else if (evict) begin
               next_state = is_wr ? mem_system_pkg::wr_writeback : mem_system_pkg::rd_writeback;
            end else begin
               next_state = is_wr ? mem_system_pkg::wr_fill : mem_system_pkg::rd_fill;
            end
         end
         mem_system_pkg::rd_writeback, mem_system_pkg::wr_writeback: begin
            // Old line goes back under its own tag
            en0         = !fill_way;
            en1         = fill_way;
            c_offset    = {cnt[1:0], 1'b0};
            mem.wr      = 1'b1;
            mem.addr    = {sel_tag, req_index, cnt[1:0], 1'b0};
            mem.data_in = sel_data;
            if (cnt == cnt_w'(3)) begin
               next_state = is_wr ? mem_system_pkg::wr_fill : mem_system_pkg::rd_fill;
            end
         end
         mem_system_pkg::rd_fill, mem_system_pkg::wr_fill: begin
            // Reads on counts 0-3 and cache writes on counts 2-5
            en0      = !fill_way;
            en1      = fill_way;
            mem.rd   = !cnt[2];
            mem.addr = {req_addr[word_w-1:offset_w], cnt[1:0], 1'b0};
            c_write  = (cnt >= cnt_w'(2));
            c_offset = {fill_word, 1'b0};
            c_data   = mem.data_out;
            if (cnt == cnt_w'(5)) begin
               next_state = is_wr ? mem_system_pkg::wr_return : mem_system_pkg::rd_return;
            end
         end
         mem_system_pkg::rd_return: begin
            en0        = !fill_way;
            en1        = fill_way;
            done       = 1'b1;
            data_out   = sel_data;
            next_state = mem_system_pkg::idle;
         end
         mem_system_pkg::wr_return: begin
            // Compare write merges the CPU word and marks the line dirty
            en0        = !fill_way;
            en1        = fill_way;
            c_comp     = 1'b1;
            c_write    = 1'b1;
            done       = 1'b1;
            next_state = mem_system_pkg::idle;
         end
         default: begin
            next_state = mem_system_pkg::idle;
         end
      endcase
   end

   // Filled line must be resident before the final access
   a_fill_resident_at_return : assert property (
      @(posedge clk) disable iff (reset)
      (state inside {mem_system_pkg::rd_return, mem_system_pkg::wr_return}) |-> real_hit
   );

   // Write-back only drains a valid dirty line from the chosen way
   a_writeback_line_dirty : assert property (
      @(posedge clk) disable iff (reset)
      in_wb |-> (fill_way ? (way1.valid && way1.dirty) : (way0.valid && way0.dirty))
   );

endmodule

// ==== src/cache_way.sv ====
////////////////////////////////////////
// Cache way
// Tag, valid, dirty and line data per set
// with a same-cycle tag compare
////////////////////////////////////////
`timescale 1ns/10ps

module cache_way #(
   parameter int sets = 256
) (
   input logic clk,
   input logic reset,
   way_if.way  bus
);

   localparam int word_w = mem_system_pkg::word_w;
   localparam int tag_w  = mem_system_pkg::tag_w;
   localparam int wpl    = mem_system_pkg::words_per_line;
   localparam int set_w  = $clog2(sets);
   localparam int wsel_w = $clog2(wpl);

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   logic [tag_w-1:0]  tag_mem  [sets];
   logic [word_w-1:0] data_mem [sets][wpl];
   logic [sets-1:0]   valid_bits;
   logic [sets-1:0]   dirty_bits;

   logic [set_w-1:0]  set_idx;
   logic [wsel_w-1:0] word_sel;
   logic              tag_eq;
   logic              cmp_wr;
   logic              fill_wr;

   // Low index bits pick the set
   assign set_idx  = bus.index[set_w-1:0];
   // Word within the line from offset[2:1]
   assign word_sel = bus.offset[wsel_w:1];
   assign tag_eq   = (tag_mem[set_idx] == bus.tag);

   // Compare write only lands on a valid matching line
   assign cmp_wr  = bus.enable && bus.comp && bus.write && tag_eq && valid_bits[set_idx];
   // Fill write from the controller during a line fill
   assign fill_wr = bus.enable && !bus.comp && bus.write;

   ////////////////////////////////////////
   // Lookup outputs
   ////////////////////////////////////////

   // Quiet outputs when the way is not selected
   assign bus.hit      = bus.enable && tag_eq;
   assign bus.valid    = bus.enable && valid_bits[set_idx];
   assign bus.dirty    = bus.enable && dirty_bits[set_idx];
   assign bus.tag_out  = bus.enable ? tag_mem[set_idx] : '0;
   assign bus.data_out = bus.enable ? data_mem[set_idx][word_sel] : '0;

   ////////////////////////////////////////
   // Updates
   ////////////////////////////////////////

   // Line state bits
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (fill_wr) begin
         // Fresh line from memory is clean
         valid_bits[set_idx] <= bus.valid_in;
         dirty_bits[set_idx] <= 1'b0;
      end else if (cmp_wr) begin
         dirty_bits[set_idx] <= 1'b1;
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk) begin
      if (fill_wr) begin
         tag_mem[set_idx] <= bus.tag;
      end
      if (fill_wr || cmp_wr) begin
         data_mem[set_idx][word_sel] <= bus.data_in;
      end
   end

   // Controller must hold comp and write low on a deselected way
   a_no_access_when_disabled : assert property (
      @(posedge clk) disable iff (reset)
      !bus.enable |-> !(bus.comp && bus.write)
   );

endmodule

// ==== src/mem_system.sv ====
////////////////////////////////////////
// Memory system top
// Two-way write-back data cache in front
// of a four-bank word memory
////////////////////////////////////////
`timescale 1ns/10ps

module mem_system #(
   parameter int mem_words = 32768,
   parameter int sets      = 256
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] addr,
   input  logic [15:0] data_in,
   input  logic        rd,
   input  logic        wr,
   output logic [15:0] data_out,
   output logic        done,
   output logic        stall,
   output logic        cache_hit
);

   // Controller links
   way_if way0_bus ();
   way_if way1_bus ();
   mem_if mem_bus ();

   // Cache ways
   cache_way #(.sets(sets)) way0 (
      .clk   (clk),
      .reset (reset),
      .bus   (way0_bus)
   );

   cache_way #(.sets(sets)) way1 (
      .clk   (clk),
      .reset (reset),
      .bus   (way1_bus)
   );

   // Backing store
   banked_mem #(.mem_words(mem_words)) memory (
      .clk   (clk),
      .reset (reset),
      .bus   (mem_bus)
   );

   cache_ctrl ctrl (
      .clk       (clk),
      .reset     (reset),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .way0      (way0_bus),
      .way1      (way1_bus),
      .mem       (mem_bus)
   );

endmodule

// ==== src/mem_system_if.sv ====
////////////////////////////////////////
// Memory system interfaces
// Controller links to each cache way and
// to the banked memory
////////////////////////////////////////
`timescale 1ns/10ps

// Controller to one cache way
interface way_if;
   // Request side
   logic [mem_system_pkg::tag_w-1:0]    tag;
   logic [mem_system_pkg::index_w-1:0]  index;
   logic [mem_system_pkg::offset_w-1:0] offset;
   logic [mem_system_pkg::word_w-1:0]   data_in;
   logic                                comp;
   logic                                write;
   logic                                valid_in;
   logic                                enable;
   // Lookup results
   logic                                hit;
   logic                                dirty;
   logic                                valid;
   logic [mem_system_pkg::tag_w-1:0]    tag_out;
   logic [mem_system_pkg::word_w-1:0]   data_out;

   modport ctrl (
      output tag, index, offset, data_in, comp, write, valid_in, enable,
      input  hit, dirty, valid, tag_out, data_out
   );
   modport way (
      input  tag, index, offset, data_in, comp, write, valid_in, enable,
      output hit, dirty, valid, tag_out, data_out
   );
endinterface

// Controller to the banked memory
interface mem_if;
   logic [mem_system_pkg::word_w-1:0] addr;
   logic [mem_system_pkg::word_w-1:0] data_in;
   logic                              wr;
   logic                              rd;
   logic [mem_system_pkg::word_w-1:0] data_out;

   modport ctrl (output addr, data_in, wr, rd, input data_out);
   modport mem  (input addr, data_in, wr, rd, output data_out);
endinterface

// ==== src/mem_system_pkg.sv ====
////////////////////////////////////////
// Memory system package
// Cache geometry, address fields and the
// controller state encoding
////////////////////////////////////////
package mem_system_pkg;

   ////////////////////////////////////////
   // Address and data geometry
   ////////////////////////////////////////

   // CPU word and byte address width
   localparam int word_w = 16;
   // Tag is addr[15:11]
   localparam int tag_w = 5;
   // Set index is addr[10:3]
   localparam int index_w = 8;
   // Byte offset in a line is addr[2:0]
   localparam int offset_w = 3;
   // Four 16-bit words per line
   localparam int words_per_line = 4;

   ////////////////////////////////////////
   // Timing and counters
   ////////////////////////////////////////

   // Read strobe to data on the memory port
   localparam int mem_rd_latency = 2;
   // Miss counter runs up to 5 during a fill
   localparam int cnt_w = 3;

   // Controller FSM states
   typedef enum logic [3:0] {
      idle         = 4'd0,
      rd_compare   = 4'd1,
      rd_writeback = 4'd2,
      rd_fill      = 4'd3,
      rd_return    = 4'd4,
      wr_compare   = 4'd5,
      wr_writeback = 4'd6,
      wr_fill      = 4'd7,
      wr_return    = 4'd8
   } ctrl_state_t;

endpackage
